//--- common/riscv_pkg.sv
package riscv_pkg;

    localparam int xlen = 32;

    typedef logic [4:0] reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    // ADDI x0, x0, 0
    localparam word_t nop_instr = 32'h0000_0013;

    // Major opcodes
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;

    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_sw  = 3'b010;
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_sub  = 7'b0100000;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        fwd_reg,
        fwd_mem_result,
        fwd_wb_result
    } fwd_sel_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_type_t;

    // One instruction word with a view per format
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
        word_t   raw;
    } instr_u;

endpackage

//--- fetch/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import riscv_pkg::*; #(
    parameter word_t reset_pc = '0
) (
    input  logic  clk,
    input  logic  rst,
    input  word_t instr_in,
    input  logic  stall,
    input  logic  redirect,
    input  word_t redirect_pc,
    output word_t pc_out,
    output word_t if_pc,
    output word_t if_instr
);

    // Redirect wins over a load-use hold
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_out <= reset_pc;
        end else if (redirect) begin
            pc_out <= redirect_pc;
        end else if (!stall) begin
            pc_out <= pc_out + 32'd4;
        end
    end

    // IF/ID instruction is squashed to a no-op on redirect
    always_ff @(posedge clk) begin
        if (rst || redirect) begin
            if_instr <= nop_instr;
        end else if (!stall) begin
            if_instr <= instr_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_pc <= pc_out;
        end
    end

endmodule

//--- decode/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import riscv_pkg::*; (
    input  instr_u    instr,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output reg_addr_t rd,
    output logic      rs1_used,
    output logic      rs2_used,
    output word_t     imm,
    output alu_op_e   alu_op,
    output logic      use_imm,
    output logic      is_load,
    output logic      is_store,
    output logic      is_branch,
    output logic      branch_ne,
    output logic      is_jal,
    output logic      reg_write
);

    word_t i_imm;
    word_t s_imm;
    word_t b_imm;
    word_t u_imm;
    word_t j_imm;
    logic  writes_rd;

    assign rs1 = instr.r.rs1;
    assign rs2 = instr.r.rs2;
    assign rd  = instr.r.rd;

    // One immediate per format view
    assign i_imm = {{20{instr.i.imm[11]}}, instr.i.imm};
    assign s_imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
    assign b_imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                    instr.b.imm10_5, instr.b.imm4_1, 1'b0};
    assign u_imm = {instr.u.imm, 12'b0};
    assign j_imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                    instr.j.imm11, instr.j.imm10_1, 1'b0};

    // x0 destinations never count as a write
    assign reg_write = writes_rd && (rd != '0);

    always_comb begin
        rs1_used  = 1'b0;
        rs2_used  = 1'b0;
        imm       = '0;
        alu_op    = alu_add;
        use_imm   = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_branch = 1'b0;
        branch_ne = 1'b0;
        is_jal    = 1'b0;
        writes_rd = 1'b0;
        case (instr.r.opcode)
            op_op: begin
                rs1_used = 1'b1;
                rs2_used = 1'b1;
                if (instr.r.funct7 == f7_base) begin
                    writes_rd = 1'b1;
                    case (instr.r.funct3)
                        f3_add:  alu_op = alu_add;
                        f3_slt:  alu_op = alu_slt;
                        f3_xor:  alu_op = alu_xor;
                        f3_or:   alu_op = alu_or;
                        f3_and:  alu_op = alu_and;
                        default: writes_rd = 1'b0;
                    endcase
                end else if (instr.r.funct7 == f7_sub && instr.r.funct3 == f3_add) begin
                    writes_rd = 1'b1;
                    alu_op    = alu_sub;
                end
            end
            op_imm: begin
                rs1_used  = 1'b1;
                use_imm   = 1'b1;
                imm       = i_imm;
                writes_rd = 1'b1;
                case (instr.i.funct3)
                    f3_add:  alu_op = alu_add;
                    f3_xor:  alu_op = alu_xor;
                    f3_or:   alu_op = alu_or;
                    f3_and:  alu_op = alu_and;
                    default: writes_rd = 1'b0;
                endcase
            end
            op_lui: begin
                use_imm   = 1'b1;
                imm       = u_imm;
                alu_op    = alu_pass_b;
                writes_rd = 1'b1;
            end
            op_load: begin
                if (instr.i.funct3 == f3_lw) begin
                    rs1_used  = 1'b1;
                    use_imm   = 1'b1;
                    imm       = i_imm;
                    is_load   = 1'b1;
                    writes_rd = 1'b1;
                end
            end
            op_store: begin
                if (instr.s.funct3 == f3_sw) begin
                    rs1_used = 1'b1;
                    rs2_used = 1'b1;
                    use_imm  = 1'b1;
                    imm      = s_imm;
                    is_store = 1'b1;
                end
            end
            op_branch: begin
                if (instr.b.funct3 == f3_beq || instr.b.funct3 == f3_bne) begin
                    rs1_used  = 1'b1;
                    rs2_used  = 1'b1;
                    imm       = b_imm;
                    is_branch = 1'b1;
                    branch_ne = (instr.b.funct3 == f3_bne);
                end
            end
            op_jal: begin
                imm       = j_imm;
                is_jal    = 1'b1;
                writes_rd = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- decode/register_file.sv
`timescale 1ns/1ps

module register_file import riscv_pkg::*; (
    input  logic      clk,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data,
    output word_t     rs1_data,
    output word_t     rs2_data
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Same-cycle writeback bypasses the array
    assign rs1_data = (rs1 == '0) ? '0 :
                      (wr_en && wr_addr == rs1) ? wr_data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 :
                      (wr_en && wr_addr == rs2) ? wr_data : regs[rs2];

endmodule

//--- rtl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import riscv_pkg::*; (
    input  reg_addr_t id_rs1,
    input  reg_addr_t id_rs2,
    input  logic      id_rs1_used,
    input  logic      id_rs2_used,
    input  reg_addr_t ex_rd,
    input  logic      ex_is_load,
    input  logic      ex_reg_write,
    input  reg_addr_t ex_rs1,
    input  reg_addr_t ex_rs2,
    input  reg_addr_t mem_rd,
    input  logic      mem_reg_write,
    input  reg_addr_t wb_rd,
    input  logic      wb_reg_write,
    output logic      load_use_stall,
    output fwd_sel_e  fwd_a,
    output fwd_sel_e  fwd_b
);

    // Youngest producer wins
    function automatic fwd_sel_e pick_source(input reg_addr_t src);
        if (src == '0) begin
            return fwd_reg;
        end else if (mem_reg_write && mem_rd == src) begin
            return fwd_mem_result;
        end else if (wb_reg_write && wb_rd == src) begin
            return fwd_wb_result;
        end
        return fwd_reg;
    endfunction

    // Load result is not ready until writeback
    assign load_use_stall = ex_is_load && ex_reg_write && (ex_rd != '0) &&
                            ((id_rs1_used && id_rs1 == ex_rd) ||
                             (id_rs2_used && id_rs2 == ex_rd));

    always_comb begin
        fwd_a = pick_source(ex_rs1);
        fwd_b = pick_source(ex_rs2);
    end

endmodule

//--- execute/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import riscv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      cache_stall,
    input  logic      bubble,
    input  reg_addr_t id_rs1,
    input  reg_addr_t id_rs2,
    input  reg_addr_t id_rd,
    input  word_t     id_imm,
    input  alu_op_e   id_alu_op,
    input  logic      id_use_imm,
    input  logic      id_is_load,
    input  logic      id_is_store,
    input  logic      id_is_branch,
    input  logic      id_branch_ne,
    input  logic      id_is_jal,
    input  logic      id_reg_write,
    input  word_t     if_pc,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    input  fwd_sel_e  fwd_a,
    input  fwd_sel_e  fwd_b,
    input  word_t     mem_result,
    input  word_t     wb_data,
    output reg_addr_t ex_rd,
    output reg_addr_t ex_rs1,
    output reg_addr_t ex_rs2,
    output logic      ex_is_load,
    output logic      ex_is_store,
    output logic      ex_reg_write,
    output logic      redirect,
    output word_t     redirect_pc,
    output word_t     alu_result,
    output word_t     store_data
);

    word_t   ex_pc;
    word_t   ex_imm;
    word_t   ex_rs1_val;
    word_t   ex_rs2_val;
    alu_op_e ex_alu_op;
    logic    ex_use_imm;
    logic    ex_is_branch;
    logic    ex_branch_ne;
    logic    ex_is_jal;
    word_t   op_a;
    word_t   op_b;
    word_t   alu_out;

    function automatic word_t forward(input fwd_sel_e sel, input word_t reg_val);
        case (sel)
            fwd_mem_result: return mem_result;
            fwd_wb_result:  return wb_data;
            default:        return reg_val;
        endcase
    endfunction

    // ID/EX control clears for a load-use bubble or a redirect
    always_ff @(posedge clk) begin
        if (rst || (!cache_stall && (bubble || redirect))) begin
            ex_is_load   <= 1'b0;
            ex_is_store  <= 1'b0;
            ex_is_branch <= 1'b0;
            ex_is_jal    <= 1'b0;
            ex_reg_write <= 1'b0;
        end else if (!cache_stall) begin
            ex_is_load   <= id_is_load;
            ex_is_store  <= id_is_store;
            ex_is_branch <= id_is_branch;
            ex_is_jal    <= id_is_jal;
            ex_reg_write <= id_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!cache_stall) begin
            ex_rs1       <= id_rs1;
            ex_rs2       <= id_rs2;
            ex_rd        <= id_rd;
            ex_imm       <= id_imm;
            ex_alu_op    <= id_alu_op;
            ex_use_imm   <= id_use_imm;
            ex_branch_ne <= id_branch_ne;
            ex_pc        <= if_pc;
            ex_rs1_val   <= rs1_data;
            ex_rs2_val   <= rs2_data;
        end
    end

    always_comb begin
        op_a       = forward(fwd_a, ex_rs1_val);
        store_data = forward(fwd_b, ex_rs2_val);
    end

    assign op_b = ex_use_imm ? ex_imm : store_data;

    always_comb begin
        case (ex_alu_op)
            alu_sub:    alu_out = op_a - op_b;
            alu_and:    alu_out = op_a & op_b;
            alu_or:     alu_out = op_a | op_b;
            alu_xor:    alu_out = op_a ^ op_b;
            alu_slt:    alu_out = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_pass_b: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    // JAL links pc+4
    assign alu_result = ex_is_jal ? ex_pc + 32'd4 : alu_out;

    // Held back while memory stalls so the PC keeps its value
    assign redirect = !cache_stall &&
                      (ex_is_jal || (ex_is_branch && ((op_a == store_data) != ex_branch_ne)));
    assign redirect_pc = ex_pc + ex_imm;

endmodule

//--- rtl/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage import riscv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      cache_stall,
    input  word_t     alu_result,
    input  word_t     store_data,
    input  logic      is_load,
    input  logic      is_store,
    input  logic      reg_write,
    input  reg_addr_t rd,
    input  word_t     read_data_in,
    output logic      mem_rd_en,
    output logic      mem_wr_en,
    output word_t     mem_addr,
    output word_t     wr_data,
    output reg_addr_t mem_rd,
    output logic      mem_reg_write,
    output word_t     mem_result,
    output logic      wb_wr_en,
    output reg_addr_t wb_rd,
    output word_t     wb_data
);

    logic wb_reg_write;

    // EX/MEM and MEM/WB control
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_rd_en     <= 1'b0;
            mem_wr_en     <= 1'b0;
            mem_reg_write <= 1'b0;
            wb_reg_write  <= 1'b0;
        end else if (!cache_stall) begin
            mem_rd_en     <= is_load;
            mem_wr_en     <= is_store;
            mem_reg_write <= reg_write;
            wb_reg_write  <= mem_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!cache_stall) begin
            mem_result <= alu_result;
            wr_data    <= store_data;
            mem_rd     <= rd;
            wb_rd      <= mem_rd;
            wb_data    <= mem_rd_en ? read_data_in : mem_result;
        end
    end

    // Data port address is the EX/MEM ALU result
    assign mem_addr = mem_result;
    assign wb_wr_en = wb_reg_write && !cache_stall;

endmodule

//--- rtl/riscv_cpu.sv
`timescale 1ns/1ps

module riscv_cpu import riscv_pkg::*; #(
    parameter word_t reset_pc = '0
) (
    input  logic  clk,
    input  logic  rst,
    input  word_t instr_in,
    input  word_t read_data_in,
    input  logic  cache_stall,
    output word_t pc_out,
    output logic  mem_rd_en,
    output logic  mem_wr_en,
    output word_t mem_addr,
    output word_t wr_data
);

    logic      pc_stall;
    logic      load_use_stall;
    logic      redirect;
    word_t     redirect_pc;
    word_t     if_pc;
    word_t     if_instr;

    // Decode stage
    reg_addr_t id_rs1;
    reg_addr_t id_rs2;
    reg_addr_t id_rd;
    logic      id_rs1_used;
    logic      id_rs2_used;
    word_t     id_imm;
    alu_op_e   id_alu_op;
    logic      id_use_imm;
    logic      id_is_load;
    logic      id_is_store;
    logic      id_is_branch;
    logic      id_branch_ne;
    logic      id_is_jal;
    logic      id_reg_write;
    word_t     rs1_data;
    word_t     rs2_data;

    // Execute stage
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;
    reg_addr_t ex_rd;
    reg_addr_t ex_rs1;
    reg_addr_t ex_rs2;
    logic      ex_is_load;
    logic      ex_is_store;
    logic      ex_reg_write;
    word_t     alu_result;
    word_t     store_data;

    // Memory and writeback stages
    reg_addr_t mem_rd;
    logic      mem_reg_write;
    word_t     mem_result;
    logic      wb_wr_en;
    reg_addr_t wb_rd;
    word_t     wb_data;

    // PC and IF/ID freeze on either stall source
    assign pc_stall = cache_stall | load_use_stall;

    fetch_stage #(
        .reset_pc(reset_pc)
    ) fetch_stage_inst (
        .clk(clk),
        .rst(rst),
        .instr_in(instr_in),
        .stall(pc_stall),
        .redirect(redirect),
        .redirect_pc(redirect_pc),
        .pc_out(pc_out),
        .if_pc(if_pc),
        .if_instr(if_instr)
    );

    instr_decoder instr_decoder_inst (
        .instr(if_instr),
        .rs1(id_rs1),
        .rs2(id_rs2),
        .rd(id_rd),
        .rs1_used(id_rs1_used),
        .rs2_used(id_rs2_used),
        .imm(id_imm),
        .alu_op(id_alu_op),
        .use_imm(id_use_imm),
        .is_load(id_is_load),
        .is_store(id_is_store),
        .is_branch(id_is_branch),
        .branch_ne(id_branch_ne),
        .is_jal(id_is_jal),
        .reg_write(id_reg_write)
    );

    register_file register_file_inst (
        .clk(clk),
        .rs1(id_rs1),
        .rs2(id_rs2),
        .wr_en(wb_wr_en),
        .wr_addr(wb_rd),
        .wr_data(wb_data),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data)
    );

    hazard_unit hazard_unit_inst (
        .id_rs1(id_rs1),
        .id_rs2(id_rs2),
        .id_rs1_used(id_rs1_used),
        .id_rs2_used(id_rs2_used),
        .ex_rd(ex_rd),
        .ex_is_load(ex_is_load),
        .ex_reg_write(ex_reg_write),
        .ex_rs1(ex_rs1),
        .ex_rs2(ex_rs2),
        .mem_rd(mem_rd),
        .mem_reg_write(mem_reg_write),
        .wb_rd(wb_rd),
        .wb_reg_write(wb_wr_en),
        .load_use_stall(load_use_stall),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b)
    );

    execute_stage execute_stage_inst (
        .clk(clk),
        .rst(rst),
        .cache_stall(cache_stall),
        .bubble(load_use_stall),
        .id_rs1(id_rs1),
        .id_rs2(id_rs2),
        .id_rd(id_rd),
        .id_imm(id_imm),
        .id_alu_op(id_alu_op),
        .id_use_imm(id_use_imm),
        .id_is_load(id_is_load),
        .id_is_store(id_is_store),
        .id_is_branch(id_is_branch),
        .id_branch_ne(id_branch_ne),
        .id_is_jal(id_is_jal),
        .id_reg_write(id_reg_write),
        .if_pc(if_pc),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b),
        .mem_result(mem_result),
        .wb_data(wb_data),
        .ex_rd(ex_rd),
        .ex_rs1(ex_rs1),
        .ex_rs2(ex_rs2),
        .ex_is_load(ex_is_load),
        .ex_is_store(ex_is_store),
        .ex_reg_write(ex_reg_write),
        .redirect(redirect),
        .redirect_pc(redirect_pc),
        .alu_result(alu_result),
        .store_data(store_data)
    );

    mem_wb_stage mem_wb_stage_inst (
        .clk(clk),
        .rst(rst),
        .cache_stall(cache_stall),
        .alu_result(alu_result),
        .store_data(store_data),
        .is_load(ex_is_load),
        .is_store(ex_is_store),
        .reg_write(ex_reg_write),
        .rd(ex_rd),
        .read_data_in(read_data_in),
        .mem_rd_en(mem_rd_en),
        .mem_wr_en(mem_wr_en),
        .mem_addr(mem_addr),
        .wr_data(wr_data),
        .mem_rd(mem_rd),
        .mem_reg_write(mem_reg_write),
        .mem_result(mem_result),
        .wb_wr_en(wb_wr_en),
        .wb_rd(wb_rd),
        .wb_data(wb_data)
    );

endmodule

//--- test/riscv_cpu_asserts.sv
`timescale 1ns/1ps

module riscv_cpu_asserts import riscv_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  cache_stall,
    input word_t pc_out,
    input logic  mem_rd_en,
    input logic  mem_wr_en
);

    // One data access per cycle
    assert property (@(posedge clk) disable iff (rst) !(mem_rd_en && mem_wr_en))
        else $error("data port read and write enabled together");

    assert property (@(posedge clk) rst |=> (!mem_rd_en && !mem_wr_en))
        else $error("data port enabled during reset");

    // PC frozen through a memory stall
    assert property (@(posedge clk) (cache_stall && !rst) |=> pc_out == $past(pc_out))
        else $error("pc_out moved while cache_stall was high");

endmodule

bind riscv_cpu riscv_cpu_asserts riscv_cpu_asserts_inst (
    .clk(clk),
    .rst(rst),
    .cache_stall(cache_stall),
    .pc_out(pc_out),
    .mem_rd_en(mem_rd_en),
    .mem_wr_en(mem_wr_en)
);

//--- test/riscv_cpu_tb.sv
`timescale 1ns/1ps

module riscv_cpu_tb import riscv_pkg::*; ();

    localparam int num_tests  = 6;
    localparam int max_prog   = 32;
    localparam int max_stores = 8;
    localparam int cycle_limit = 300;
    localparam int drain_cycles = 12;
    // Each test runs reset, its cycle limit and a drain phase
    localparam int watchdog_ns = num_tests * (cycle_limit + drain_cycles + 4) * 40 + 1000;

    logic  clk;
    logic  rst;
    logic  cache_stall;
    word_t instr_in;
    word_t read_data_in;
    word_t pc_out;
    logic  mem_rd_en;
    logic  mem_wr_en;
    word_t mem_addr;
    word_t wr_data;

    word_t imem [1024];
    word_t dmem [1024];

    // Test table
    string names [num_tests];
    word_t prog [num_tests][max_prog];
    int    prog_len [num_tests];
    word_t exp_addr [num_tests][max_stores];
    word_t exp_data [num_tests][max_stores];
    int    exp_len [num_tests];
    bit    stall_en [num_tests];

    word_t  st_addr [$];
    word_t  st_data [$];
    integer seed = 2;
    int     errors = 0;
    int     checks = 0;

    riscv_cpu riscv_cpu_inst (
        .clk(clk),
        .rst(rst),
        .instr_in(instr_in),
        .read_data_in(read_data_in),
        .cache_stall(cache_stall),
        .pc_out(pc_out),
        .mem_rd_en(mem_rd_en),
        .mem_wr_en(mem_wr_en),
        .mem_addr(mem_addr),
        .wr_data(wr_data)
    );

    assign instr_in     = imem[pc_out[11:2]];
    assign read_data_in = dmem[mem_addr[11:2]];

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout: the simulation ran past its time budget");
        $display("TEST FAILED");
        $finish;
    end

    // Instruction encoders
    function automatic word_t enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op_op};
    endfunction

    function automatic word_t enc_i(logic [6:0] op, int imm, int rs1, logic [2:0] f3, int rd);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic word_t enc_sw(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3_sw, imm[4:0], op_store};
    endfunction

    function automatic word_t enc_b(int imm, int rs1, int rs2, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic word_t enc_lui(int imm20, int rd);
        return {imm20[19:0], rd[4:0], op_lui};
    endfunction

    function automatic word_t enc_jal(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], op_jal};
    endfunction

    // Data memory background is unique per word index
    function automatic word_t fill_word(int idx);
        return {~idx[15:0], idx[15:0]};
    endfunction

    task automatic add_instr(int t, word_t w);
        prog[t][prog_len[t]] = w;
        prog_len[t]++;
    endtask

    task automatic add_store(int t, word_t addr, word_t data);
        exp_addr[t][exp_len[t]] = addr;
        exp_data[t][exp_len[t]] = data;
        exp_len[t]++;
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic build_table();
        for (int t = 0; t < num_tests; t++) begin
            prog_len[t] = 0;
            exp_len[t]  = 0;
            stall_en[t] = (t >= 3);
        end
        // Dependent ALU chain
        names[0] = "arith_forwarding";
        add_instr(0, enc_i(op_imm, 5, 0, f3_add, 1));
        add_instr(0, enc_i(op_imm, 7, 1, f3_add, 2));
        add_instr(0, enc_r(f7_base, 2, 1, f3_add, 3));
        add_instr(0, enc_r(f7_sub, 1, 3, f3_add, 4));
        add_instr(0, enc_r(f7_base, 4, 3, f3_or, 6));
        add_instr(0, enc_r(f7_base, 3, 4, f3_slt, 8));
        add_instr(0, enc_lui(32'h12345, 9));
        add_instr(0, enc_i(op_imm, 32'h678, 9, f3_or, 9));
        add_instr(0, enc_i(op_imm, -1, 9, f3_xor, 10));
        add_instr(0, enc_i(op_imm, 32'hff, 10, f3_and, 11));
        add_instr(0, enc_i(op_imm, 9, 0, f3_add, 0));
        add_instr(0, enc_sw(32'h100, 3, 0));
        add_instr(0, enc_sw(32'h104, 6, 0));
        add_instr(0, enc_sw(32'h108, 8, 0));
        add_instr(0, enc_sw(32'h10c, 10, 0));
        add_instr(0, enc_sw(32'h110, 11, 0));
        add_instr(0, enc_sw(32'h114, 0, 0));
        add_instr(0, enc_jal(0, 0));
        add_store(0, 32'h100, 32'd17);
        add_store(0, 32'h104, 32'h1d);
        add_store(0, 32'h108, 32'd1);
        add_store(0, 32'h10c, 32'hedcb_a987);
        add_store(0, 32'h110, 32'h87);
        add_store(0, 32'h114, 32'h0);
        // Loads feeding the very next instruction
        names[1] = "load_use";
        add_instr(1, enc_i(op_imm, 32'h123, 0, f3_add, 1));
        add_instr(1, enc_sw(32'h80, 1, 0));
        add_instr(1, enc_i(op_load, 32'h80, 0, f3_lw, 2));
        add_instr(1, enc_r(f7_base, 1, 2, f3_add, 3));
        add_instr(1, enc_sw(32'h84, 3, 0));
        add_instr(1, enc_i(op_load, 32'h84, 0, f3_lw, 4));
        add_instr(1, enc_sw(32'h88, 4, 0));
        add_instr(1, enc_i(op_load, 32'h200, 0, f3_lw, 5));
        add_instr(1, enc_i(op_imm, 1, 5, f3_add, 6));
        add_instr(1, enc_sw(32'h8c, 6, 0));
        add_instr(1, enc_jal(0, 0));
        add_store(1, 32'h80, 32'h123);
        add_store(1, 32'h84, 32'h246);
        add_store(1, 32'h88, 32'h246);
        add_store(1, 32'h8c, fill_word(32'h200 >> 2) + 32'd1);
        // Marker stores in x7 sit on the skipped paths
        names[2] = "branch_flush";
        add_instr(2, enc_i(op_imm, 3, 0, f3_add, 1));
        add_instr(2, enc_i(op_imm, 3, 0, f3_add, 2));
        add_instr(2, enc_i(op_imm, 32'h7ff, 0, f3_add, 7));
        add_instr(2, enc_b(12, 1, 2, f3_beq));
        add_instr(2, enc_sw(32'h300, 7, 0));
        add_instr(2, enc_sw(32'h304, 7, 0));
        add_instr(2, enc_sw(32'h308, 1, 0));
        add_instr(2, enc_b(12, 1, 0, f3_bne));
        add_instr(2, enc_sw(32'h30c, 7, 0));
        add_instr(2, enc_sw(32'h310, 7, 0));
        add_instr(2, enc_jal(12, 5));
        add_instr(2, enc_sw(32'h314, 7, 0));
        add_instr(2, enc_sw(32'h318, 7, 0));
        add_instr(2, enc_sw(32'h31c, 5, 0));
        add_instr(2, enc_b(8, 1, 0, f3_beq));
        add_instr(2, enc_sw(32'h320, 2, 0));
        add_instr(2, enc_jal(0, 0));
        add_store(2, 32'h308, 32'd3);
        add_store(2, 32'h31c, 32'd40 + 32'd4);
        add_store(2, 32'h320, 32'd3);
        // Same programs again under random memory stalls
        for (int t = 3; t < num_tests; t++) begin
            names[t]    = {names[t-3], "_stalled"};
            prog[t]     = prog[t-3];
            prog_len[t] = prog_len[t-3];
            exp_addr[t] = exp_addr[t-3];
            exp_data[t] = exp_data[t-3];
            exp_len[t]  = exp_len[t-3];
        end
    endtask

    // Stores are taken at mid-cycle where the data port is settled
    task automatic step_cycle(bit random_stall);
        int r;
        @(posedge clk);
        #2;
        r = random_stall ? $random(seed) : 0;
        cache_stall = random_stall && r[0];
        @(negedge clk);
        if (mem_wr_en && !cache_stall) begin
            dmem[mem_addr[11:2]] = wr_data;
            st_addr.push_back(mem_addr);
            st_data.push_back(wr_data);
        end
    endtask

    task automatic run_test(int t);
        int cycles;
        int err_before;
        err_before = errors;
        @(posedge clk);
        #2;
        rst = 1'b1;
        cache_stall = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            imem[i] = (i < prog_len[t]) ? prog[t][i] : nop_instr;
            dmem[i] = fill_word(i);
        end
        st_addr.delete();
        st_data.delete();
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        #1;
        check_word("pc_out", pc_out, 32'h0);
        check_flag("mem_rd_en", mem_rd_en, 1'b0);
        check_flag("mem_wr_en", mem_wr_en, 1'b0);
        cycles = 0;
        while (st_addr.size() < exp_len[t] && cycles < cycle_limit) begin
            step_cycle(stall_en[t]);
            cycles++;
        end
        // Wrong-path stores would show up here
        repeat (drain_cycles) step_cycle(1'b0);
        if (st_addr.size() < exp_len[t]) begin
            errors++;
            $display("%s: only %0d of %0d stores seen within %0d cycles",
                     names[t], st_addr.size(), exp_len[t], cycle_limit);
        end else if (st_addr.size() > exp_len[t]) begin
            errors++;
            $display("%s: %0d stores seen but only %0d expected",
                     names[t], st_addr.size(), exp_len[t]);
        end
        for (int k = 0; k < exp_len[t] && k < st_addr.size(); k++) begin
            check_word("mem_addr", st_addr[k], exp_addr[t][k]);
            check_word("wr_data", st_data[k], exp_data[t][k]);
        end
        $display("%s: %s after %0d cycles", names[t],
                 (errors == err_before) ? "pass" : "fail", cycles);
    endtask

    initial begin
        rst = 1'b1;
        cache_stall = 1'b0;
        build_table();
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d checks, %0d errors", num_tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- riscv_cpu.f
common/riscv_pkg.sv
fetch/fetch_stage.sv
decode/instr_decoder.sv
decode/register_file.sv
rtl/hazard_unit.sv
execute/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/riscv_cpu.sv
test/riscv_cpu_asserts.sv
test/riscv_cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       := riscv_cpu_tb
FILELIST  := riscv_cpu.f
OBJ_DIR   := obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
